// File: rtl/bank_arbiter.sv
//////////////////////////////
// Bank arbiter
// Shares one SDRAM request port between two slots
// with round-robin priority
//////////////////////////////
module bank_arbiter (
    input  logic                   clk,
    input  logic                   arst_n,

    // Slot 0
    input  logic                   s0_req,
    input  sdram_pkg::sdram_addr_t s0_addr,
    output logic                   s0_ack,
    output logic                   s0_rdy,

    // Slot 1
    input  logic                   s1_req,
    input  sdram_pkg::sdram_addr_t s1_addr,
    output logic                   s1_ack,
    output logic                   s1_rdy,

    // SDRAM bank
    output logic                   sdram_req,
    output sdram_pkg::sdram_addr_t sdram_addr,
    input  logic                   sdram_ack,
    input  logic                   data_rdy
);

    logic busy;          // One request outstanding on the bank
    logic owner;         // Slot holding the bank
    logic last_served;   // Slot whose read completed last
    logic any_req;
    logic winner;

    assign any_req = s0_req | s1_req;

    // On a tie the slot not served last goes first
    assign winner = (s0_req && s1_req) ? ~last_served : s1_req;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy        <= 1'b0;
            owner       <= 1'b0;
            last_served <= 1'b1;   // slot 0 wins the first tie
            sdram_req   <= 1'b0;
        end else begin
            if (!busy) begin
                if (any_req) begin
                    busy      <= 1'b1;
                    owner     <= winner;
                    sdram_req <= 1'b1;
                end
            end else begin
                if (sdram_req && sdram_ack) begin
                    sdram_req <= 1'b0;
                end
                // Data back, bank is free again
                if (data_rdy) begin
                    busy        <= 1'b0;
                    last_served <= owner;
                end
            end
        end
    end

    // Owner keeps its address steady until its data returns
    assign sdram_addr = owner ? s1_addr : s0_addr;

    // Handshakes go back to the owner only
    assign s0_ack = busy && !owner && sdram_ack;
    assign s1_ack = busy &&  owner && sdram_ack;
    assign s0_rdy = busy && !owner && data_rdy;
    assign s1_rdy = busy &&  owner && data_rdy;

endmodule

// File: rtl/rom_bank.sv
//////////////////////////////
// ROM bank
// Sound and graphics ROM slots sharing one
// SDRAM bank through a round-robin arbiter
//////////////////////////////
module rom_bank #(
    parameter int                     SND_AW     = 19,
    parameter int                     GFX_AW     = 20,
    parameter sdram_pkg::sdram_addr_t SND_OFFSET = sdram_pkg::snd_offset_default,
    parameter sdram_pkg::sdram_addr_t GFX_OFFSET = sdram_pkg::gfx_offset_default
) (
    input  logic                   clk,
    input  logic                   arst_n,

    // Sound CPU
    input  logic                   snd_cs,
    input  logic [SND_AW-1:0]      snd_addr,
    output logic                   snd_ok,
    output sdram_pkg::word16_t     snd_data,

    // Graphics
    input  logic                   gfx_cs,
    input  logic [GFX_AW-1:0]      gfx_addr,
    output logic                   gfx_ok,
    output sdram_pkg::word32_t     gfx_data,

    // SDRAM bank
    output logic                   sdram_req,
    output sdram_pkg::sdram_addr_t sdram_addr,
    input  logic                   sdram_ack,
    input  logic                   data_rdy,
    input  sdram_pkg::word16_t     data_read
);
    import sdram_pkg::*;

    // Slot 0 is sound, slot 1 graphics
    logic        s0_req;
    sdram_addr_t s0_addr;
    logic        s0_ack;
    logic        s0_rdy;
    logic        s1_req;
    sdram_addr_t s1_addr;
    logic        s1_ack;
    logic        s1_rdy;

    rom_slot #(
        .data_t     ( word16_t      ),
        .AW         ( SND_AW        ),
        .OFFSET     ( SND_OFFSET    )
    ) i_snd_slot (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .cs         ( snd_cs        ),
        .addr       ( snd_addr      ),
        .ok         ( snd_ok        ),
        .data       ( snd_data      ),
        .req        ( s0_req        ),
        .sdram_addr ( s0_addr       ),
        .ack        ( s0_ack        ),
        .rdy        ( s0_rdy        ),
        .data_read  ( data_read     )
    );

    rom_slot #(
        .data_t     ( word32_t      ),   // two reads per word
        .AW         ( GFX_AW        ),
        .OFFSET     ( GFX_OFFSET    )
    ) i_gfx_slot (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .cs         ( gfx_cs        ),
        .addr       ( gfx_addr      ),
        .ok         ( gfx_ok        ),
        .data       ( gfx_data      ),
        .req        ( s1_req        ),
        .sdram_addr ( s1_addr       ),
        .ack        ( s1_ack        ),
        .rdy        ( s1_rdy        ),
        .data_read  ( data_read     )
    );

    bank_arbiter i_arbiter (
        .clk        ( clk           ),
        .arst_n     ( arst_n        ),
        .s0_req     ( s0_req        ),
        .s0_addr    ( s0_addr       ),
        .s0_ack     ( s0_ack        ),
        .s0_rdy     ( s0_rdy        ),
        .s1_req     ( s1_req        ),
        .s1_addr    ( s1_addr       ),
        .s1_ack     ( s1_ack        ),
        .s1_rdy     ( s1_rdy        ),
        .sdram_req  ( sdram_req     ),
        .sdram_addr ( sdram_addr    ),
        .sdram_ack  ( sdram_ack     ),
        .data_rdy   ( data_rdy      )
    );

endmodule

// File: rtl/rom_slot.sv
//////////////////////////////
// ROM slot
// Keeps the last fetched payload, compares the client
// address against it and fetches 16-bit SDRAM words
// on a miss, lowest word first
//////////////////////////////
module rom_slot #(
    parameter type                    data_t = sdram_pkg::word16_t,
    parameter int                     AW     = 19,
    parameter sdram_pkg::sdram_addr_t OFFSET = sdram_pkg::snd_offset_default
) (
    input  logic                   clk,
    input  logic                   arst_n,

    // Client port
    input  logic                   cs,
    input  logic [AW-1:0]          addr,
    output logic                   ok,
    output data_t                  data,

    // Towards the bank arbiter
    output logic                   req,
    output sdram_pkg::sdram_addr_t sdram_addr,
    input  logic                   ack,
    input  logic                   rdy,
    input  sdram_pkg::word16_t     data_read
);
    import sdram_pkg::*;

    localparam int NWORDS = $bits(data_t) / word_bits;   // SDRAM reads per payload
    localparam int SHIFT  = $clog2(NWORDS);
    localparam int CW     = (NWORDS > 1) ? SHIFT : 1;

    logic [AW-1:0]            last_addr;    // Address of the cached or running fetch
    logic                     valid;        // Payload holds last_addr
    logic                     busy;         // Fetch under way
    logic [CW-1:0]            word_cnt;
    logic [$bits(data_t)-1:0] payload;

    logic                     hit;
    logic                     pending;
    logic                     miss;
    logic                     last_word;
    logic                     fetch_done;
    sdram_addr_t              base_addr;

    // First SDRAM word of the client address
    assign base_addr = OFFSET + (sdram_addr_t'(addr) << SHIFT);

    assign hit       = valid && (addr == last_addr);
    assign pending   = busy && (addr == last_addr);   // already being fetched
    assign miss      = cs && !hit && !pending;
    assign last_word = (word_cnt == CW'(NWORDS - 1));

    // Final word arrives and nobody asked for something else meanwhile
    assign fetch_done = busy && rdy && last_word && !miss;

    // Sequencer
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_addr  <= '0;
            valid      <= 1'b0;
            busy       <= 1'b0;
            req        <= 1'b0;
            word_cnt   <= '0;
            sdram_addr <= '0;
        end else begin
            if (req && ack) begin
                req <= 1'b0;   // Request taken, now wait for data
            end

            if (miss && (!busy || rdy)) begin
                // New fetch, or restart once the current word is in
                busy       <= 1'b1;
                valid      <= 1'b0;
                req        <= 1'b1;
                last_addr  <= addr;
                word_cnt   <= '0;
                sdram_addr <= base_addr;
            end else if (busy && rdy) begin
                if (last_word) begin
                    busy  <= 1'b0;
                    valid <= 1'b1;
                end else begin
                    // Next half of the payload
                    word_cnt   <= word_cnt + 1'b1;
                    sdram_addr <= sdram_addr + 1'b1;
                    req        <= 1'b1;
                end
            end
        end
    end

    // Payload assembly, one 16-bit lane per returned word
    always_ff @(posedge clk) begin
        if (busy && rdy) begin
            payload[word_cnt*word_bits +: word_bits] <= data_read;
        end
    end

    // ok follows cs and the address with one cycle of delay
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ok <= 1'b0;
        end else begin
            ok <= cs && (hit || fetch_done);
        end
    end

    assign data = data_t'(payload);

endmodule

// File: rtl/sdram_pkg.sv
//////////////////////////////
// SDRAM bank definitions
// Address and payload types shared by the
// ROM slots, the arbiter and the top level
//////////////////////////////
package sdram_pkg;

    // One SDRAM bank holds 8M words of 16 bits
    localparam int sdram_aw  = 23;
    localparam int word_bits = 16;   // Width of one SDRAM read

    // Word address into the bank
    typedef logic [sdram_aw-1:0] sdram_addr_t;

    // Client payloads
    typedef logic [word_bits-1:0]   word16_t;   // Sound CPU, one read
    typedef logic [2*word_bits-1:0] word32_t;   // Graphics, two reads

    // Region bases inside the bank
    // Sound ROM sits high, graphics start at the bottom
    localparam sdram_addr_t snd_offset_default = 23'h38_0000;
    localparam sdram_addr_t gfx_offset_default = 23'h00_0000;

endpackage

// File: verification/rom_bank_asserts.sv
//////////////////////////////
// ROM bank handshake checks
// SDRAM request rules and client ok rules
//////////////////////////////
module rom_bank_asserts (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   snd_cs,
    input  logic                   snd_ok,
    input  sdram_pkg::word16_t     snd_data,
    input  logic                   gfx_cs,
    input  logic                   gfx_ok,
    input  sdram_pkg::word32_t     gfx_data,
    input  logic                   sdram_req,
    input  logic                   sdram_ack,
    input  sdram_pkg::sdram_addr_t sdram_addr
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;   // Failed assertions so far

    // Request held until the bank takes it
    req_held: assert property (@(posedge clk) disable iff (!arst_n)
        sdram_req && !sdram_ack |=> sdram_req)
        else begin
            fail_count++;
            $error("sdram_req dropped before sdram_ack");
        end

    req_addr_stable: assert property (@(posedge clk) disable iff (!arst_n)
        sdram_req && !sdram_ack |=> $stable(sdram_addr))
        else begin
            fail_count++;
            $error("sdram_addr changed while sdram_req was waiting");
        end

    // Payload steady while ok stays high
    snd_data_held: assert property (@(posedge clk) disable iff (!arst_n)
        snd_ok |=> !snd_ok || $stable(snd_data))
        else begin
            fail_count++;
            $error("snd_data changed while snd_ok stayed high");
        end

    gfx_data_held: assert property (@(posedge clk) disable iff (!arst_n)
        gfx_ok |=> !gfx_ok || $stable(gfx_data))
        else begin
            fail_count++;
            $error("gfx_data changed while gfx_ok stayed high");
        end

    // Both clients served from their caches
    no_req_on_hits: assert property (@(posedge clk) disable iff (!arst_n)
        snd_cs && snd_ok && gfx_cs && gfx_ok |-> !sdram_req)
        else begin
            fail_count++;
            $error("sdram_req high while both clients hit");
        end

endmodule

bind rom_bank rom_bank_asserts i_asserts (
    .clk        ( clk        ),
    .arst_n     ( arst_n     ),
    .snd_cs     ( snd_cs     ),
    .snd_ok     ( snd_ok     ),
    .snd_data   ( snd_data   ),
    .gfx_cs     ( gfx_cs     ),
    .gfx_ok     ( gfx_ok     ),
    .gfx_data   ( gfx_data   ),
    .sdram_req  ( sdram_req  ),
    .sdram_ack  ( sdram_ack  ),
    .sdram_addr ( sdram_addr )
);

// File: verification/rom_bank_tb.sv
//////////////////////////////
// ROM bank testbench
// Table of sound and graphics reads against a
// random-latency SDRAM model
//////////////////////////////
module rom_bank_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import sdram_pkg::*;

    localparam int          SND_AW     = 19;
    localparam int          GFX_AW     = 20;
    localparam sdram_addr_t SND_OFFSET = snd_offset_default;
    localparam sdram_addr_t GFX_OFFSET = gfx_offset_default;
    localparam logic [15:0] DATA_KEY   = 16'h5A3C;   // Model data = address XOR key
    localparam int          HIT_WATCH  = 3;   // Slot req plus arbiter stage, and one spare

    localparam logic [1:0] SEL_SND  = 2'b01;
    localparam logic [1:0] SEL_GFX  = 2'b10;
    localparam logic [1:0] SEL_BOTH = 2'b11;

    typedef struct packed {
        logic [1:0]        sel;
        logic [SND_AW-1:0] snd_addr;
        logic [GFX_AW-1:0] gfx_addr;
        logic              snd_hit;
        logic              gfx_hit;
    } row_t;

    logic              clk;
    logic              arst_n;
    logic              snd_cs;
    logic [SND_AW-1:0] snd_addr;
    logic              snd_ok;
    word16_t           snd_data;
    logic              gfx_cs;
    logic [GFX_AW-1:0] gfx_addr;
    logic              gfx_ok;
    word32_t           gfx_data;
    logic              sdram_req;
    sdram_addr_t       sdram_addr;
    logic              sdram_ack;
    logic              data_rdy;
    word16_t           data_read;

    row_t rows[$];
    int   cycle_cnt     = 0;
    int   timeout_limit = 100;
    logic req_seen      = 1'b0;   // Set by the bus monitor

    rom_bank #(
        .SND_AW     ( SND_AW     ),
        .GFX_AW     ( GFX_AW     ),
        .SND_OFFSET ( SND_OFFSET ),
        .GFX_OFFSET ( GFX_OFFSET )
    ) i_dut (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .snd_cs     ( snd_cs     ),
        .snd_addr   ( snd_addr   ),
        .snd_ok     ( snd_ok     ),
        .snd_data   ( snd_data   ),
        .gfx_cs     ( gfx_cs     ),
        .gfx_addr   ( gfx_addr   ),
        .gfx_ok     ( gfx_ok     ),
        .gfx_data   ( gfx_data   ),
        .sdram_req  ( sdram_req  ),
        .sdram_addr ( sdram_addr ),
        .sdram_ack  ( sdram_ack  ),
        .data_rdy   ( data_rdy   ),
        .data_read  ( data_read  )
    );

    sdram_model #(
        .SEED       ( 32'hf1f8e095 ),
        .DATA_KEY   ( DATA_KEY     )
    ) i_sdram (
        .clk        ( clk        ),
        .sdram_req  ( sdram_req  ),
        .sdram_addr ( sdram_addr ),
        .sdram_ack  ( sdram_ack  ),
        .data_rdy   ( data_rdy   ),
        .data_read  ( data_read  )
    );

    initial begin
        forever begin
            clk = 1'b0;
            #50;
            clk = 1'b1;
            #50;
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // Expected ROM contents
    function automatic word16_t rom_word(sdram_addr_t a);
        return a[15:0] ^ DATA_KEY;
    endfunction

    function automatic word16_t sound_word(logic [SND_AW-1:0] a);
        return rom_word(SND_OFFSET + sdram_addr_t'(a));
    endfunction

    function automatic word32_t graphics_word(logic [GFX_AW-1:0] a);
        sdram_addr_t lo;
        lo = GFX_OFFSET + (sdram_addr_t'(a) << 1);
        return {rom_word(lo + 1'b1), rom_word(lo)};   // Low half read first
    endfunction

    function automatic bit in_region(sdram_addr_t a);
        int unsigned ai;
        int unsigned snd_lo;
        int unsigned gfx_lo;
        ai     = a;
        snd_lo = SND_OFFSET;
        gfx_lo = GFX_OFFSET;
        return (ai >= snd_lo && ai < snd_lo + (1 << SND_AW)) ||
               (ai >= gfx_lo && ai < gfx_lo + (1 << (GFX_AW + 1)));
    endfunction

    task automatic add_row(input logic [1:0] sel, input logic [SND_AW-1:0] sa,
                           input logic [GFX_AW-1:0] ga, input logic sh, input logic gh);
        rows.push_back('{sel, sa, ga, sh, gh});
    endtask

    task automatic build_table();
        add_row(SEL_SND,  19'h00000, 20'h00000, 1'b0, 1'b0);   // Address 0 misses after reset
        add_row(SEL_SND,  19'h00000, 20'h00000, 1'b1, 1'b0);
        add_row(SEL_GFX,  19'h00000, 20'h00000, 1'b0, 1'b0);
        add_row(SEL_GFX,  19'h00000, 20'h00000, 1'b0, 1'b1);
        add_row(SEL_SND,  19'h12345, 20'h00000, 1'b0, 1'b0);
        add_row(SEL_GFX,  19'h00000, 20'h0ABCD, 1'b0, 1'b0);
        add_row(SEL_BOTH, 19'h12345, 20'h0ABCD, 1'b1, 1'b1);
        add_row(SEL_BOTH, 19'h7FFFF, 20'hFFFFF, 1'b0, 1'b0);   // Region tops
        add_row(SEL_BOTH, 19'h00100, 20'h00200, 1'b0, 1'b0);
        add_row(SEL_BOTH, 19'h00100, 20'h54321, 1'b1, 1'b0);
        add_row(SEL_BOTH, 19'h2AAAA, 20'h54321, 1'b0, 1'b1);
        add_row(SEL_BOTH, 19'h01234, 20'h43210, 1'b0, 1'b0);
        add_row(SEL_GFX,  19'h00000, 20'h43210, 1'b0, 1'b1);
        add_row(SEL_SND,  19'h01234, 20'h00000, 1'b1, 1'b0);
        add_row(SEL_BOTH, 19'h3C3C3, 20'h0F0F0, 1'b0, 1'b0);
        add_row(SEL_BOTH, 19'h3C3C3, 20'h0F0F0, 1'b1, 1'b1);
    endtask

    task automatic run_row(input row_t r, input int idx);
        logic    use_snd;
        logic    use_gfx;
        logic    all_hit;
        word16_t exp_snd;
        word32_t exp_gfx;
        use_snd  = r.sel[0];
        use_gfx  = r.sel[1];
        all_hit  = (!use_snd || r.snd_hit) && (!use_gfx || r.gfx_hit);
        req_seen = 1'b0;
        if (use_snd) begin
            snd_addr = r.snd_addr;
            snd_cs   = 1'b1;
        end
        if (use_gfx) begin
            gfx_addr = r.gfx_addr;
            gfx_cs   = 1'b1;
        end
        next_cycle();
        // A hit answers after one cycle, a miss cannot
        if (use_snd) begin
            assert (snd_ok === r.snd_hit) else stop_on_error($sformatf(
                "Error at %0t ns: snd_ok expected %0b, got %0b", $time, r.snd_hit, snd_ok));
        end
        if (use_gfx) begin
            assert (gfx_ok === r.gfx_hit) else stop_on_error($sformatf(
                "Error at %0t ns: gfx_ok expected %0b, got %0b", $time, r.gfx_hit, gfx_ok));
        end
        while (!((!use_snd || snd_ok) && (!use_gfx || gfx_ok))) begin
            next_cycle();
        end
        if (use_snd) begin
            exp_snd = sound_word(r.snd_addr);
            assert (snd_data === exp_snd) else stop_on_error($sformatf(
                "Error at %0t ns: snd_data expected %h, got %h", $time, exp_snd, snd_data));
        end
        if (use_gfx) begin
            exp_gfx = graphics_word(r.gfx_addr);
            assert (gfx_data === exp_gfx) else stop_on_error($sformatf(
                "Error at %0t ns: gfx_data expected %h, got %h", $time, exp_gfx, gfx_data));
        end
        if (all_hit) begin
            // cs stays up long enough for a stray fetch to reach the bank
            repeat (HIT_WATCH) next_cycle();
            assert (!req_seen) else stop_on_error($sformatf(
                "Row %0d should hit on every port but reached the SDRAM", idx));
        end
        snd_cs = 1'b0;
        gfx_cs = 1'b0;
        next_cycle();
    endtask

    // Every bank request must land in one of the two ROM regions
    always @(posedge clk) begin
        if (arst_n && sdram_req) begin
            req_seen = 1'b1;
            assert (in_region(sdram_addr)) else stop_on_error($sformatf(
                "SDRAM address %h at %0t ns is outside both ROM regions", sdram_addr, $time));
        end
    end

    always @(posedge clk) begin
        if (i_dut.i_asserts.fail_count != 0) begin
            stop_on_error("A handshake assertion on the ROM bank failed");
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_limit) begin
            stop_on_error($sformatf("Timeout, the run did not end within %0d cycles",
                                    timeout_limit));
        end
    end

    initial begin
        $timeformat(-9, 0, "", 0);
        arst_n   = 1'b0;
        snd_cs   = 1'b0;
        snd_addr = '0;
        gfx_cs   = 1'b0;
        gfx_addr = '0;
        build_table();
        timeout_limit = rows.size() * 40 + 100;

        repeat (2) begin
            next_cycle();
            assert (!sdram_req && !snd_ok && !gfx_ok) else
                stop_on_error("sdram_req, snd_ok or gfx_ok is high during reset");
        end
        arst_n = 1'b1;
        next_cycle();
        assert (!sdram_req && !snd_ok && !gfx_ok) else
            stop_on_error("sdram_req, snd_ok or gfx_ok is high right after reset");

        foreach (rows[i]) begin
            run_row(rows[i], i);
        end

        if (i_dut.i_asserts.fail_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_on_error("A handshake assertion on the ROM bank failed during the run");
        end
    end

endmodule

// File: verification/sdram_model.sv
//////////////////////////////
// SDRAM bank model
// Acks each request and returns one pattern word
// after random delays
//////////////////////////////
module sdram_model #(
    parameter logic [31:0] SEED     = 32'h0,
    parameter logic [15:0] DATA_KEY = 16'h0
) (
    input  logic                   clk,
    input  logic                   sdram_req,
    input  sdram_pkg::sdram_addr_t sdram_addr,
    output logic                   sdram_ack,
    output logic                   data_rdy,
    output sdram_pkg::word16_t     data_read
);
    timeunit 1ns;
    timeprecision 100ps;

    import sdram_pkg::*;

    sdram_addr_t addr;
    int unsigned ack_delay;
    int unsigned rdy_delay;

    // Outputs move 1 ns after the edge, like the testbench inputs
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    initial begin
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        void'($urandom(SEED));
        forever begin
            next_cycle();
            if (sdram_req) begin
                addr      = sdram_addr;
                ack_delay = $urandom_range(3, 0);
                rdy_delay = $urandom_range(5, 2);   // Counted from the ack
                repeat (ack_delay) next_cycle();
                sdram_ack = 1'b1;
                next_cycle();
                sdram_ack = 1'b0;
                repeat (rdy_delay - 1) next_cycle();
                data_rdy  = 1'b1;
                data_read = addr[15:0] ^ DATA_KEY;
                next_cycle();
                data_rdy  = 1'b0;
            end
        end
    end

endmodule

// File: vlog.f
rtl/sdram_pkg.sv
rtl/rom_slot.sv
rtl/bank_arbiter.sv
rtl/rom_bank.sv
verification/sdram_model.sv
verification/rom_bank_asserts.sv
verification/rom_bank_tb.sv
